// ==== rv_pkg.sv ====
// shared widths, reset pc, opcode and funct3 constants, and the core's enum types.
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes of the supported subset.
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  localparam logic [31:0] inst_ebreak = 32'h0010_0073;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {
    imm_i, imm_u, imm_j, imm_b
  } imm_kind_t;

  typedef enum logic [2:0] {
    pc_seq, pc_branch_eq, pc_branch_ne, pc_jal, pc_jalr, pc_halt
  } pc_kind_t;

endpackage

`default_nettype wire

// ==== key_mux.sv ====
// key-matched selector with a type-parameter payload and an optional default value.
`timescale 1ns/1ps
`default_nettype none

module key_mux #(
  parameter int  nr_key      = 2,
  parameter int  key_w       = 1,
  parameter type data_t      = logic,
  parameter bit  has_default = 1'b0
) (
  input  logic [key_w-1:0] key,
  input  logic [key_w-1:0] keys [nr_key],
  input  data_t            values [nr_key],
  input  data_t            default_value,
  output data_t            out
);

  logic [$bits(data_t)-1:0] acc;
  logic                     hit;

  // every matching entry is ORed in, so keys are expected to be unique.
  always_comb begin
    acc = '0;
    hit = 1'b0;
    for (int n = 0; n < nr_key; n++) begin
      acc = acc | ({$bits(data_t){key == keys[n]}} & values[n]);
      hit = hit | (key == keys[n]);
    end
  end

  always_comb begin
    if (has_default && !hit) begin
      out = default_value;
    end else begin
      out = data_t'(acc);
    end
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// integer register file with two combinational read ports and one write port.
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          rd_en,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  input  logic [rv_pkg::xlen-1:0]       rd_data
);
  import rv_pkg::*;

  // x0 has no storage behind it.
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
// instruction decoder producing register fields, immediate, ALU controls and pc kind.
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  logic [31:0]                   inst,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  output logic                          rd_en,
  output logic [rv_pkg::xlen-1:0]       imm,
  output rv_pkg::alu_op_t               alu_op,
  output logic                          use_pc_a,
  output logic                          use_imm_b,
  output rv_pkg::pc_kind_t              pc_kind
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  imm_kind_t  imm_kind;
  alu_op_t    f3_op;
  logic       writes_rd;

  logic [6:0]      kind_keys [4];
  imm_kind_t       kind_vals [4];
  logic [1:0]      imm_keys  [4];
  logic [xlen-1:0] imm_vals  [4];
  logic [2:0]      f3_keys   [5];
  alu_op_t         f3_vals   [5];

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rd_addr  = inst[11:7];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  // op_imm, jalr and anything unknown fall back to the i-type immediate.
  assign kind_keys = '{op_lui, op_auipc, op_jal, op_branch};
  assign kind_vals = '{imm_u, imm_u, imm_j, imm_b};

  key_mux #(.nr_key(4), .key_w(7), .data_t(imm_kind_t), .has_default(1'b1)) u_kind_mux (
    .key(opcode), .keys(kind_keys), .values(kind_vals),
    .default_value(imm_i), .out(imm_kind)
  );

  assign imm_keys    = '{imm_i, imm_u, imm_j, imm_b};
  assign imm_vals[0] = {{20{inst[31]}}, inst[31:20]};
  assign imm_vals[1] = {inst[31:12], 12'b0};
  assign imm_vals[2] = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_vals[3] = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  key_mux #(.nr_key(4), .key_w(2), .data_t(logic [xlen-1:0])) u_imm_mux (
    .key(imm_kind), .keys(imm_keys), .values(imm_vals),
    .default_value('0), .out(imm)
  );

  assign f3_keys = '{f3_add, f3_slt, f3_xor, f3_or, f3_and};
  assign f3_vals = '{alu_add, alu_slt, alu_xor, alu_or, alu_and};

  key_mux #(.nr_key(5), .key_w(3), .data_t(alu_op_t), .has_default(1'b1)) u_f3_mux (
    .key(funct3), .keys(f3_keys), .values(f3_vals),
    .default_value(alu_add), .out(f3_op)
  );

  always_comb begin
    alu_op    = alu_add;
    writes_rd = 1'b1;
    case (opcode)
      op_lui:   alu_op = alu_pass_b;
      op_imm:   alu_op = f3_op;
      op_reg:   alu_op = (f3_op == alu_add && inst[30]) ? alu_sub : f3_op;
      op_auipc, op_jal, op_jalr: alu_op = alu_add;
      default:  writes_rd = 1'b0;
    endcase
  end

  assign rd_en     = writes_rd && (rd_addr != '0);
  assign use_pc_a  = (opcode == op_auipc);
  assign use_imm_b = (opcode != op_reg);

  always_comb begin
    pc_kind = pc_seq;
    if (opcode == op_jal) begin
      pc_kind = pc_jal;
    end else if (opcode == op_jalr) begin
      pc_kind = pc_jalr;
    end else if (opcode == op_branch && funct3 == f3_beq) begin
      pc_kind = pc_branch_eq;
    end else if (opcode == op_branch && funct3 == f3_bne) begin
      pc_kind = pc_branch_ne;
    end else if (inst == inst_ebreak) begin
      pc_kind = pc_halt;
    end
  end

endmodule

`default_nettype wire

// ==== alu.sv ====
// integer ALU for the supported RV32I subset.
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_t         op,
  output logic [rv_pkg::xlen-1:0] result
);
  import rv_pkg::*;

  logic [2:0]      op_keys [7];
  logic [xlen-1:0] op_vals [7];
  logic            less;

  assign less = $signed(a) < $signed(b);

  assign op_keys = '{alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b};

  assign op_vals[0] = a + b;
  assign op_vals[1] = a - b;
  assign op_vals[2] = a & b;
  assign op_vals[3] = a | b;
  assign op_vals[4] = a ^ b;
  assign op_vals[5] = {{(xlen-1){1'b0}}, less};
  // lui reaches the result through pass-b.
  assign op_vals[6] = b;

  // every legal op has a key, so no default is needed.
  key_mux #(
    .nr_key(7),
    .key_w (3),
    .data_t(logic [xlen-1:0])
  ) u_op_mux (
    .key          (op),
    .keys         (op_keys),
    .values       (op_vals),
    .default_value('0),
    .out          (result)
  );

endmodule

`default_nettype wire

// ==== next_pc.sv ====
// program counter register, sticky halt flag and next-pc target selection.
`timescale 1ns/1ps
`default_nettype none

module next_pc (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::pc_kind_t        pc_kind,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] jalr_target,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] link,
  output logic                    halt
);
  import rv_pkg::*;

  logic [xlen-1:0] branch_target;
  logic [xlen-1:0] target;
  logic            equal;
  logic [2:0]      kind_keys [6];
  logic [xlen-1:0] kind_vals [6];

  assign link          = pc + 32'd4;
  assign branch_target = pc + imm;
  assign equal         = (rs1_data == rs2_data);

  assign kind_keys = '{pc_seq, pc_branch_eq, pc_branch_ne, pc_jal, pc_jalr, pc_halt};
  assign kind_vals = '{link, equal ? branch_target : link, equal ? link : branch_target,
                       branch_target, {jalr_target[xlen-1:1], 1'b0}, pc};

  key_mux #(.nr_key(6), .key_w(3), .data_t(logic [xlen-1:0])) u_target_mux (
    .key(pc_kind), .keys(kind_keys), .values(kind_vals),
    .default_value('0), .out(target)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      pc <= target;
      if (pc_kind == pc_halt) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
// single-cycle RV32I subset core top level with a write-back trace at its ports.
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [31:0]                   inst,
  output logic [rv_pkg::xlen-1:0]       pc,
  output logic                          wb_en,
  output logic [rv_pkg::reg_addr_w-1:0] wb_addr,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          halt
);
  import rv_pkg::*;

  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [reg_addr_w-1:0] rd_addr;
  logic                  rd_en;
  logic [xlen-1:0]       imm;
  alu_op_t               alu_op;
  logic                  use_pc_a;
  logic                  use_imm_b;
  pc_kind_t              pc_kind;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       op_a;
  logic [xlen-1:0]       op_b;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       link;

  inst_decode u_decode (
    .inst(inst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .rd_en(rd_en), .imm(imm), .alu_op(alu_op), .use_pc_a(use_pc_a),
    .use_imm_b(use_imm_b), .pc_kind(pc_kind)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .rd_en(wb_en),
    .rd_addr(wb_addr), .rd_data(wb_data)
  );

  assign op_a = use_pc_a ? pc : rs1_data;
  assign op_b = use_imm_b ? imm : rs2_data;

  alu u_alu (.a(op_a), .b(op_b), .op(alu_op), .result(alu_result));

  // the ALU sum rs1 + imm doubles as the jalr target.
  next_pc u_next_pc (
    .clk(clk), .rst(rst), .pc_kind(pc_kind), .imm(imm), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .jalr_target(alu_result), .pc(pc), .link(link), .halt(halt)
  );

  // in reset or once halted, nothing is written back.
  assign wb_en   = rd_en && !halt && !rst;
  assign wb_addr = rd_addr;
  assign wb_data = (pc_kind == pc_jal || pc_kind == pc_jalr) ? link : alu_result;

endmodule

`default_nettype wire

// ==== rv_core_asserts.sv ====
// concurrent checks on rv_core reset pc, pc alignment, write-back address and halt.
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts (
  input logic                          clk,
  input logic                          rst,
  input logic [rv_pkg::xlen-1:0]       pc,
  input logic                          wb_en,
  input logic [rv_pkg::reg_addr_w-1:0] wb_addr,
  input logic                          halt
);
  import rv_pkg::*;

  a_reset_pc: assert property (@(posedge clk) rst |=> pc == reset_pc)
    else $error("pc differs from the reset pc in the cycle after reset");

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // x0 writes are dropped in decode, so none may reach the trace.
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_addr != '0)
    else $error("write-back to x0 is visible on the ports");

  a_halt_freeze: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else $error("pc moved while the core was halted");

endmodule

bind rv_core rv_core_asserts u_asserts (.*);

`default_nettype wire

// ==== tb_rv_core.sv ====
// testbench for rv_core that serves a program and checks the write trace and halt pc.
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam logic [31:0] nop = {25'b0, op_imm};
  // addi x1, x0, 0x7ff would write x1 and advance pc if the core still ran.
  localparam logic [31:0] addi_x1 = {12'h7ff, 5'd0, f3_add, 5'd1, op_imm};

  logic                  clk;
  logic                  rst;
  logic [31:0]           inst;
  logic [xlen-1:0]       pc;
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0]       wb_data;
  logic                  halt;

  logic [31:0] prog [256];
  logic [31:0] exp_rd [$];
  logic [31:0] exp_val [$];
  logic [31:0] halt_pc;
  int          nr_writes = 0;

  rv_core u_dut (
    .clk(clk), .rst(rst), .inst(inst), .pc(pc), .wb_en(wb_en),
    .wb_addr(wb_addr), .wb_data(wb_data), .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // word fetch from the program image; anything outside it reads as a nop.
  function automatic logic [31:0] fetch(input logic [31:0] addr);
    logic [31:0] offset;
    offset = (addr - reset_pc) >> 2;
    if (addr < reset_pc || offset > 32'd255) begin
      fetch = nop;
    end else begin
      fetch = prog[offset[7:0]];
    end
  endfunction

  task automatic load_stimulus();
    int                fd;
    int                n;
    logic [7:0]        tag;
    logic [8*80-1:0]   line;
    logic [31:0]       a;
    logic [31:0]       b;
    foreach (prog[i]) begin
      prog[i] = nop;
    end
    fd = $fopen("rv_core_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_failure("could not open rv_core_stimulus.txt");
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        n = $fgets(line, fd);
      end else if (tag == "I") begin
        n = $fscanf(fd, "%h %h", a, b);
        prog[a[7:0]] = b;
      end else if (tag == "W") begin
        n = $fscanf(fd, "%h %h", a, b);
        exp_rd.push_back(a);
        exp_val.push_back(b);
      end else if (tag == "P") begin
        n = $fscanf(fd, "%h", halt_pc);
      end else begin
        stop_with_failure("unknown line kind in rv_core_stimulus.txt");
      end
    end
    $fclose(fd);
  endtask

  // each write is compared at the edge that commits it.
  always @(posedge clk) begin
    if (wb_en) begin
      if (exp_rd.size() == 0) begin
        stop_with_failure($sformatf("unexpected write of %h to x%0d", wb_data, wb_addr));
      end else begin
        check($sformatf("write %0d rd", nr_writes), exp_rd.pop_front(), 32'(wb_addr));
        check($sformatf("write %0d value", nr_writes), exp_val.pop_front(), wb_data);
        nr_writes++;
      end
    end
  end

  initial begin
    int cycles;
    rst     = 1'b1;
    inst    = nop;
    halt_pc = '0;
    load_stimulus();
    // the program is served during reset too, so a writing first word is seen.
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check("reset pc", reset_pc, pc);
      check("reset wb_en", 32'd0, 32'(wb_en));
      check("reset halt", 32'd0, 32'(halt));
      inst = fetch(pc);
    end
    rst = 1'b0;
    check("first cycle pc", reset_pc, pc);
    check("first cycle halt", 32'd0, 32'(halt));
    cycles = 0;
    while (!halt) begin
      @(negedge clk);
      inst = fetch(pc);
      cycles++;
      if (cycles > 200) begin
        stop_with_failure("the core did not halt within 200 cycles");
      end
    end
    check("halt pc", halt_pc, pc);
    inst = addi_x1;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check("pc after halt", halt_pc, pc);
      check("wb_en after halt", 32'd0, 32'(wb_en));
    end
    if (exp_rd.size() != 0) begin
      stop_with_failure($sformatf("%0d expected writes never happened", exp_rd.size()));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
rv_pkg.sv
key_mux.sv
reg_file.sv
inst_decode.sv
alu.sv
next_pc.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the rv_core testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f rv_core.f; then
  echo "verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/Vtb_rv_core 2>&1); then
  echo "$output"
  echo "simulation exited with an error"
  exit 1
fi
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// ==== rv_core_stimulus.txt ====
# I <word offset> <inst> | W <rd> <value> | P <halt pc>, all hex
I 00 123450b7
I 01 00001117
I 02 ffb00193
I 03 0011a213
I 04 0ff0c293
I 05 7f026313
I 06 0f02f393
I 07 00308433
I 08 403204b3
I 09 0062f533
I 0a 0093e5b3
I 0b 0050c633
I 0c 0001a6b3
I 0d 00108013
I 0e 00900733
I 0f 00e48463
I 10 7ff00793
I 11 00308463
I 12 02a00793
I 13 00309463
I 14 7ff00793
I 15 0080086f
I 16 7ff00793
I 17 00c808e7
I 18 7ff00793
I 19 00100073
W 01 12345000
W 02 80001004
W 03 fffffffb
W 04 00000001
W 05 123450ff
W 06 000007f1
W 07 000000f0
W 08 12344ffb
W 09 00000006
W 0a 000000f1
W 0b 000000f6
W 0c 000000ff
W 0d 00000001
W 0e 00000006
W 0f 0000002a
W 10 80000058
W 11 80000060
P 80000064
